// File: flist.f
hdl/wb_pkg.sv
hdl/wb_result_select.sv
hdl/wb_exception_latch.sv
hdl/wb_stall_ctrl.sv
hdl/iterative_divider.sv
hdl/regfile_3w.sv
hdl/ex2_wb_top.sv
sim/tb_ex2_wb.sv

// File: sim/tb_ex2_wb.sv
`timescale 1ns/1ns
module tb_ex2_wb;
    import wb_pkg::*;

    localparam int TIMEOUT = 100;
    localparam int N_STIM  = 17;

    localparam logic [2:0] K_ALU  = 3'd0;
    localparam logic [2:0] K_CSR  = 3'd1;
    localparam logic [2:0] K_DIV  = 3'd2;
    localparam logic [2:0] K_LOAD = 3'd3;
    localparam logic [2:0] K_EXC  = 3'd4;
    localparam logic [2:0] K_ERTN = 3'd5;

    localparam uop_t U_NONE = '0;
    localparam uop_t U_DIV  = uop_t'(1 << UOP_DIV);
    localparam uop_t U_ERTN = uop_t'(1 << UOP_ERTN);
    localparam uop_t U_LINK = uop_t'(1 << UOP_LINK);
    localparam uop_t U_REM  = uop_t'(1 << UOP_REM);

    // code is the lane 1 rd for alu, zero divisor for div, ecode for exceptions
    typedef struct packed {
        logic [2:0] kind;
        logic       lane;
        uop_t       uop;
        reg_idx_t   rd;
        logic [6:0] code;
    } stim_t;

    logic     clk;
    logic     aresetn;
    uop_t     uop0, uop1;
    reg_idx_t rd0, rd1, ld_rd, rf_raddr;
    word_t    result0, result1, pc0, csr_data, dividend, divisor, ld_data;
    logic     result_valid0, result_valid1, csr_rd_en0, div_start, ld_issue, dcache_ready;
    logic     exception_in, cpu_interrupt;
    ecode_t   ecode_in;
    word_t    badv_in, era_in, csr_era, eentry, tlbrentry;

    logic        wb_we0, wb_we1, wb_we2;
    reg_idx_t    wb_rd0, wb_rd1, wb_rd2;
    word_t       wb_data0, wb_data1, wb_data2;
    logic        ex2_allowin, exception_out, wen_badv, wen_vppn, wen_era;
    logic        tlb_exception, redirect_valid;
    ecode_t      ecode_out;
    word_t       badv_out, era_out, redirect_pc, rf_rdata;
    logic [18:0] vppn_out;

    stim_t       stim [0:N_STIM-1];
    word_t       model [0:31];
    logic [31:0] written;
    logic [31:0] lcg_state;
    int          checks;
    int          mismatches;
    int          timeouts;
    int          idx;

    ex2_wb_top ex2_wb_top_inst (.*);

    always #20 clk = ~clk;

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic stim_t make_entry(input logic [2:0] kind, input logic lane,
                                         input uop_t uop, input reg_idx_t rd,
                                         input logic [6:0] code);
        stim_t s;
        s.kind = kind;
        s.lane = lane;
        s.uop  = uop;
        s.rd   = rd;
        s.code = code;
        return s;
    endfunction

    // {badv write, vppn write} for an exception code
    function automatic logic [1:0] fault_writes(input ecode_t c);
        case (c)
            EXP_ADEF, EXP_ALE: return 2'b10;
            EXP_PIL, EXP_PIS, EXP_PIF, EXP_PME, EXP_PPI, EXP_TLBR: return 2'b11;
            default: return 2'b00;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic record_write(input reg_idx_t rd, input word_t data);
        if (rd != '0) begin
            model[rd]   = data;
            written[rd] = 1'b1;
        end
    endtask

    task automatic fill_table();
        stim[0]  = make_entry(K_ALU,  1'b0, U_NONE,        5'd5,  7'd6);
        stim[1]  = make_entry(K_ALU,  1'b0, U_LINK,        5'd1,  7'd2);
        // both lanes on r7
        stim[2]  = make_entry(K_ALU,  1'b0, U_NONE,        5'd7,  7'd7);
        stim[3]  = make_entry(K_ALU,  1'b0, U_NONE,        5'd0,  7'd3);
        stim[4]  = make_entry(K_CSR,  1'b0, U_NONE,        5'd8,  7'd0);
        stim[5]  = make_entry(K_DIV,  1'b0, U_DIV,         5'd9,  7'd0);
        stim[6]  = make_entry(K_DIV,  1'b0, U_DIV | U_REM, 5'd10, 7'd0);
        stim[7]  = make_entry(K_DIV,  1'b1, U_DIV,         5'd11, 7'd0);
        stim[8]  = make_entry(K_DIV,  1'b0, U_DIV,         5'd12, 7'd1);
        stim[9]  = make_entry(K_DIV,  1'b1, U_DIV | U_REM, 5'd13, 7'd1);
        stim[10] = make_entry(K_LOAD, 1'b0, U_NONE,        5'd14, 7'd0);
        stim[11] = make_entry(K_LOAD, 1'b0, U_NONE,        5'd15, 7'd0);
        stim[12] = make_entry(K_EXC,  1'b0, U_NONE,        5'd0,  EXP_ADEF);
        stim[13] = make_entry(K_EXC,  1'b0, U_NONE,        5'd0,  EXP_PIL);
        stim[14] = make_entry(K_EXC,  1'b0, U_ERTN,        5'd0,  EXP_TLBR);
        stim[15] = make_entry(K_EXC,  1'b0, U_ERTN,        5'd0,  EXP_SYS);
        stim[16] = make_entry(K_ERTN, 1'b0, U_ERTN,        5'd0,  7'd0);
    endtask

    task automatic alu_writeback(input stim_t s);
        word_t exp0;
        result0       = next_rand();
        result1       = next_rand();
        pc0           = next_rand() & ~32'h3;
        uop0          = s.uop;
        rd0           = s.rd;
        rd1           = s.code[4:0];
        result_valid0 = 1'b1;
        result_valid1 = 1'b1;
        exp0 = s.uop[UOP_LINK] ? pc0 + 32'd4 : result0;
        @(negedge clk);
        check_value("wb_we0", 1, wb_we0);
        check_value("wb_rd0", s.rd, wb_rd0);
        check_value("wb_data0", exp0, wb_data0);
        check_value("wb_we1", 1, wb_we1);
        check_value("wb_rd1", s.code[4:0], wb_rd1);
        check_value("wb_data1", result1, wb_data1);
        record_write(s.rd, exp0);
        record_write(s.code[4:0], result1);
        result_valid0 = 1'b0;
        result_valid1 = 1'b0;
        uop0          = U_NONE;
    endtask

    task automatic csr_read(input stim_t s);
        csr_data   = next_rand();
        csr_rd_en0 = 1'b1;
        rd0        = s.rd;
        uop0       = s.uop;
        @(negedge clk);
        check_value("wb_we0", 1, wb_we0);
        check_value("wb_rd0", s.rd, wb_rd0);
        check_value("wb_data0", csr_data, wb_data0);
        check_value("wb_we1", 0, wb_we1);
        record_write(s.rd, csr_data);
        csr_rd_en0 = 1'b0;
    endtask

    task automatic divide_op(input stim_t s);
        word_t a;
        word_t b;
        word_t expd;
        int    k;
        logic  seen;
        a = next_rand();
        b = s.code[0] ? 32'd0 : (next_rand() >> (next_rand() % 24));
        if (b == 32'd0) begin
            expd = s.uop[UOP_REM] ? a : 32'hffff_ffff;
        end else begin
            expd = s.uop[UOP_REM] ? a % b : a / b;
        end
        dividend  = a;
        divisor   = b;
        div_start = 1'b1;
        if (s.lane) begin
            uop1 = s.uop;
            rd1  = s.rd;
        end else begin
            uop0 = s.uop;
            rd0  = s.rd;
        end
        @(negedge clk);
        div_start = 1'b0;
        k    = 1;
        seen = s.lane ? wb_we1 : wb_we0;
        while (!seen && k < TIMEOUT) begin
            // lane 0 holds upstream until the divider is ready
            if (!s.lane) begin
                check_value("ex2_allowin", k == DIV_STEPS + 1, ex2_allowin);
            end
            @(negedge clk);
            k++;
            seen = s.lane ? wb_we1 : wb_we0;
        end
        if (!seen) begin
            $display("timeout: no divide result written back on lane %0d", s.lane);
            timeouts++;
        end else begin
            check_value("divide latency", DIV_STEPS + 2, k);
            check_value($sformatf("wb_rd%0d", s.lane), s.rd, s.lane ? wb_rd1 : wb_rd0);
            check_value($sformatf("wb_data%0d", s.lane), expd,
                        s.lane ? wb_data1 : wb_data0);
            record_write(s.rd, expd);
        end
        uop0 = U_NONE;
        uop1 = U_NONE;
    endtask

    task automatic load_return(input stim_t s);
        int    k;
        int    extra;
        word_t data;
        word_t other;
        check_value("ex2_allowin", 1, ex2_allowin);
        ld_issue = 1'b1;
        @(negedge clk);
        ld_issue = 1'b0;
        k = 1;
        while (ex2_allowin && k < TIMEOUT) begin
            @(negedge clk);
            k++;
        end
        if (ex2_allowin) begin
            $display("timeout: ex2_allowin never fell with a load pending");
            timeouts++;
        end else begin
            check_value("load stall cycle", 2, k);
        end
        extra = next_rand() % 4;
        repeat (extra) begin
            @(negedge clk);
            check_value("ex2_allowin", 0, ex2_allowin);
        end
        data          = next_rand();
        other         = next_rand();
        ld_data       = data;
        ld_rd         = s.rd;
        dcache_ready  = 1'b1;
        // lane 1 hits the same register so port 2 must win
        rd1           = s.rd;
        result1       = other;
        result_valid1 = 1'b1;
        @(negedge clk);
        check_value("wb_we2", 1, wb_we2);
        check_value("wb_rd2", s.rd, wb_rd2);
        check_value("wb_data2", data, wb_data2);
        check_value("wb_we1", 1, wb_we1);
        check_value("wb_data1", other, wb_data1);
        check_value("ex2_allowin", 1, ex2_allowin);
        record_write(s.rd, other);
        record_write(s.rd, data);
        dcache_ready  = 1'b0;
        result_valid1 = 1'b0;
    endtask

    task automatic raise_exception(input stim_t s);
        word_t      badv;
        word_t      era;
        logic       tlbr;
        logic [1:0] wr;
        badv         = next_rand();
        era          = next_rand() | 32'h1;
        tlbr         = (s.code == EXP_TLBR);
        wr           = fault_writes(s.code);
        exception_in = 1'b1;
        ecode_in     = s.code;
        badv_in      = badv;
        era_in       = era;
        uop0         = s.uop;
        @(negedge clk);
        check_value("exception_out", 1, exception_out);
        check_value("ecode_out", s.code, ecode_out);
        check_value("wen_badv", wr[1], wen_badv);
        check_value("wen_vppn", wr[0], wen_vppn);
        check_value("tlb_exception", tlbr, tlb_exception);
        check_value("badv_out", badv, badv_out);
        check_value("vppn_out", badv[18:0], vppn_out);
        check_value("wen_era", 1, wen_era);
        check_value("era_out", era, era_out);
        check_value("redirect_valid", 1, redirect_valid);
        check_value("redirect_pc", tlbr ? tlbrentry : eentry, redirect_pc);
        exception_in = 1'b0;
        era_in       = '0;
        uop0         = U_NONE;
        @(negedge clk);
        check_value("exception_out", 0, exception_out);
        check_value("redirect_valid", 0, redirect_valid);
        // a zero era_in leaves the last era in place
        check_value("era_out", era, era_out);
    endtask

    task automatic return_from_exception(input stim_t s);
        csr_era = next_rand() & ~32'h3;
        uop0    = s.uop;
        @(negedge clk);
        check_value("exception_out", 0, exception_out);
        check_value("redirect_valid", 1, redirect_valid);
        check_value("redirect_pc", csr_era, redirect_pc);
        uop0 = U_NONE;
    endtask

    initial begin
        clk           = 1'b0;
        aresetn       = 1'b0;
        uop0          = U_NONE;
        uop1          = U_NONE;
        rd0           = '0;
        rd1           = '0;
        result0       = '0;
        result1       = '0;
        result_valid0 = 1'b0;
        result_valid1 = 1'b0;
        pc0           = '0;
        csr_rd_en0    = 1'b0;
        csr_data      = '0;
        div_start     = 1'b0;
        dividend      = '0;
        divisor       = '0;
        ld_issue      = 1'b0;
        ld_data       = '0;
        ld_rd         = '0;
        dcache_ready  = 1'b0;
        exception_in  = 1'b0;
        ecode_in      = '0;
        badv_in       = '0;
        era_in        = '0;
        cpu_interrupt = 1'b0;
        csr_era       = '0;
        eentry        = 32'h1c00_4000;
        tlbrentry     = 32'h1c00_8000;
        rf_raddr      = '0;
        lcg_state     = 32'd98;
        checks        = 0;
        mismatches    = 0;
        timeouts      = 0;
        written       = '0;
        fill_table();

        repeat (10) @(negedge clk);
        check_value("wb_we0", 0, wb_we0);
        check_value("wb_we1", 0, wb_we1);
        check_value("wb_we2", 0, wb_we2);
        check_value("wen_badv", 0, wen_badv);
        check_value("wen_vppn", 0, wen_vppn);
        check_value("wen_era", 0, wen_era);
        check_value("exception_out", 0, exception_out);
        check_value("tlb_exception", 0, tlb_exception);
        check_value("redirect_valid", 0, redirect_valid);
        check_value("ex2_allowin", 1, ex2_allowin);
        aresetn = 1'b1;
        @(negedge clk);

        for (idx = 0; idx < N_STIM; idx++) begin
            case (stim[idx].kind)
                K_ALU:   alu_writeback(stim[idx]);
                K_CSR:   csr_read(stim[idx]);
                K_DIV:   divide_op(stim[idx]);
                K_LOAD:  load_return(stim[idx]);
                K_EXC:   raise_exception(stim[idx]);
                default: return_from_exception(stim[idx]);
            endcase
        end

        // last writes land at the next edge
        @(negedge clk);
        for (idx = 0; idx < 32; idx++) begin
            rf_raddr = idx[4:0];
            @(negedge clk);
            if (idx == 0) begin
                check_value("rf_rdata r0", 0, rf_rdata);
            end else if (written[idx]) begin
                check_value($sformatf("rf_rdata r%0d", idx), model[idx], rf_rdata);
            end
        end

        $display("%0d checks, %0d mismatches, %0d timeouts", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: hdl/ex2_wb_top.sv
`timescale 1ns/1ns
module ex2_wb_top (
    input  logic             clk,
    input  logic             aresetn,
    input  wb_pkg::uop_t     uop0,
    input  wb_pkg::uop_t     uop1,
    input  wb_pkg::reg_idx_t rd0,
    input  wb_pkg::reg_idx_t rd1,
    input  wb_pkg::word_t    result0,
    input  wb_pkg::word_t    result1,
    input  logic             result_valid0,
    input  logic             result_valid1,
    input  wb_pkg::word_t    pc0,
    input  logic             csr_rd_en0,
    input  wb_pkg::word_t    csr_data,
    input  logic             div_start,
    input  wb_pkg::word_t    dividend,
    input  wb_pkg::word_t    divisor,
    input  logic             ld_issue,
    input  wb_pkg::word_t    ld_data,
    input  wb_pkg::reg_idx_t ld_rd,
    input  logic             dcache_ready,
    input  logic             exception_in,
    input  wb_pkg::ecode_t   ecode_in,
    input  wb_pkg::word_t    badv_in,
    input  wb_pkg::word_t    era_in,
    input  logic             cpu_interrupt,
    input  wb_pkg::word_t    csr_era,
    input  wb_pkg::word_t    eentry,
    input  wb_pkg::word_t    tlbrentry,
    input  wb_pkg::reg_idx_t rf_raddr,
    output logic             wb_we0,
    output logic             wb_we1,
    output logic             wb_we2,
    output wb_pkg::reg_idx_t wb_rd0,
    output wb_pkg::reg_idx_t wb_rd1,
    output wb_pkg::reg_idx_t wb_rd2,
    output wb_pkg::word_t    wb_data0,
    output wb_pkg::word_t    wb_data1,
    output wb_pkg::word_t    wb_data2,
    output logic             ex2_allowin,
    output logic             exception_out,
    output wb_pkg::ecode_t   ecode_out,
    output wb_pkg::word_t    badv_out,
    output logic             wen_badv,
    output logic [18:0]      vppn_out,
    output logic             wen_vppn,
    output wb_pkg::word_t    era_out,
    output logic             wen_era,
    output logic             tlb_exception,
    output wb_pkg::word_t    redirect_pc,
    output logic             redirect_valid,
    output wb_pkg::word_t    rf_rdata
);
    import wb_pkg::*;

    word_t quotient;
    word_t remainder;
    logic  div_busy;
    logic  div_ready;

    // a start while the divider is occupied is dropped
    iterative_divider iterative_divider_inst (
        .clk       (clk),
        .aresetn   (aresetn),
        .start     (div_start & ~div_busy),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder),
        .busy      (div_busy),
        .ready     (div_ready)
    );

    wb_result_select wb_result_select_inst (
        .clk           (clk),
        .aresetn       (aresetn),
        .uop0          (uop0),
        .uop1          (uop1),
        .rd0           (rd0),
        .rd1           (rd1),
        .pc0           (pc0),
        .result0       (result0),
        .result1       (result1),
        .csr_data      (csr_data),
        .quotient      (quotient),
        .remainder     (remainder),
        .ld_data       (ld_data),
        .result_valid0 (result_valid0),
        .result_valid1 (result_valid1),
        .csr_rd_en0    (csr_rd_en0),
        .div_ready     (div_ready),
        .dcache_ready  (dcache_ready),
        .ld_rd         (ld_rd),
        .wb_we0        (wb_we0),
        .wb_we1        (wb_we1),
        .wb_we2        (wb_we2),
        .wb_rd0        (wb_rd0),
        .wb_rd1        (wb_rd1),
        .wb_rd2        (wb_rd2),
        .wb_data0      (wb_data0),
        .wb_data1      (wb_data1),
        .wb_data2      (wb_data2)
    );

    wb_exception_latch wb_exception_latch_inst (
        .clk            (clk),
        .aresetn        (aresetn),
        .exception_in   (exception_in),
        .cpu_interrupt  (cpu_interrupt),
        .ecode_in       (ecode_in),
        .badv_in        (badv_in),
        .era_in         (era_in),
        .csr_era        (csr_era),
        .eentry         (eentry),
        .tlbrentry      (tlbrentry),
        .pc0            (pc0),
        .uop0           (uop0),
        .exception_out  (exception_out),
        .wen_badv       (wen_badv),
        .wen_vppn       (wen_vppn),
        .wen_era        (wen_era),
        .tlb_exception  (tlb_exception),
        .redirect_valid (redirect_valid),
        .ecode_out      (ecode_out),
        .badv_out       (badv_out),
        .era_out        (era_out),
        .redirect_pc    (redirect_pc),
        .vppn_out       (vppn_out)
    );

    // any redirect drops the loads in flight
    wb_stall_ctrl wb_stall_ctrl_inst (
        .clk          (clk),
        .aresetn      (aresetn),
        .ld_issue     (ld_issue),
        .dcache_ready (dcache_ready),
        .div_pending  (uop0[UOP_DIV]),
        .div_ready    (div_ready),
        .flush        (redirect_valid),
        .ex2_allowin  (ex2_allowin)
    );

    regfile_3w regfile_3w_inst (
        .clk     (clk),
        .aresetn (aresetn),
        .we0     (wb_we0),
        .we1     (wb_we1),
        .we2     (wb_we2),
        .waddr0  (wb_rd0),
        .waddr1  (wb_rd1),
        .waddr2  (wb_rd2),
        .wdata0  (wb_data0),
        .wdata1  (wb_data1),
        .wdata2  (wb_data2),
        .raddr   (rf_raddr),
        .rdata   (rf_rdata)
    );

endmodule

// File: hdl/regfile_3w.sv
`timescale 1ns/1ns
module regfile_3w (
    input  logic             clk,
    input  logic             aresetn,
    input  logic             we0,
    input  logic             we1,
    input  logic             we2,
    input  wb_pkg::reg_idx_t waddr0,
    input  wb_pkg::reg_idx_t waddr1,
    input  wb_pkg::reg_idx_t waddr2,
    input  wb_pkg::word_t    wdata0,
    input  wb_pkg::word_t    wdata1,
    input  wb_pkg::word_t    wdata2,
    input  wb_pkg::reg_idx_t raddr,
    output wb_pkg::word_t    rdata
);
    import wb_pkg::*;

    word_t regs [0:31];

    // later port overrides earlier on the same address
    always_ff @(posedge clk) begin
        if (aresetn) begin
            if (we0 && waddr0 != '0) begin
                regs[waddr0] <= wdata0;
            end
            if (we1 && waddr1 != '0) begin
                regs[waddr1] <= wdata1;
            end
            if (we2 && waddr2 != '0) begin
                regs[waddr2] <= wdata2;
            end
        end
    end

    // r0 is never written
    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

// File: hdl/iterative_divider.sv
`timescale 1ns/1ns
module iterative_divider (
    input  logic          clk,
    input  logic          aresetn,
    input  logic          start,
    input  wb_pkg::word_t dividend,
    input  wb_pkg::word_t divisor,
    output wb_pkg::word_t quotient,
    output wb_pkg::word_t remainder,
    output logic          busy,
    output logic          ready
);
    import wb_pkg::*;

    div_state_t                   state;
    logic [$clog2(DIV_STEPS)-1:0] step;
    word_t                        quo_q;
    word_t                        rem_q;
    word_t                        dvsr_q;
    logic [32:0]                  rem_shift;
    logic [32:0]                  rem_sub;
    logic                         take;

    // one restoring step
    assign rem_shift = {rem_q, quo_q[31]};
    assign take      = rem_shift >= {1'b0, dvsr_q};
    assign rem_sub   = take ? rem_shift - {1'b0, dvsr_q} : rem_shift;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= DIV_IDLE;
            step  <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state <= DIV_BUSY;
                        step  <= '0;
                    end
                end
                DIV_BUSY: begin
                    step <= step + 1'b1;
                    if (step == $bits(step)'(DIV_STEPS - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    // zero divisor yields all ones and keeps the dividend as remainder
    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            quo_q  <= dividend;
            rem_q  <= '0;
            dvsr_q <= divisor;
        end else if (state == DIV_BUSY) begin
            quo_q <= {quo_q[30:0], take};
            rem_q <= rem_sub[31:0];
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;
    assign busy      = (state != DIV_IDLE);
    assign ready     = (state == DIV_DONE);

endmodule

// File: hdl/wb_stall_ctrl.sv
`timescale 1ns/1ns
module wb_stall_ctrl (
    input  logic clk,
    input  logic aresetn,
    input  logic ld_issue,
    input  logic dcache_ready,
    input  logic div_pending,
    input  logic div_ready,
    input  logic flush,
    output logic ex2_allowin
);
    logic [2:0] ld_pend;
    logic [2:0] oldest;
    logic [2:0] kept;
    logic       ld_stall;
    logic       div_stall;

    // the returning load retires the oldest entry
    always_comb begin
        if (ld_pend[2]) begin
            oldest = 3'b100;
        end else if (ld_pend[1]) begin
            oldest = 3'b010;
        end else begin
            oldest = {2'b00, ld_pend[0]};
        end
    end

    assign kept = dcache_ready ? (ld_pend & ~oldest) : ld_pend;

    // bit 2 holds a load that is still waiting
    always_ff @(posedge clk) begin
        if (!aresetn || flush) begin
            ld_pend <= 3'b000;
        end else begin
            ld_pend <= {kept[2] | kept[1], kept[0], ld_issue & ex2_allowin};
        end
    end

    assign ld_stall    = (ld_pend[1] | ld_pend[2]) & ~dcache_ready;
    assign div_stall   = div_pending & ~div_ready;
    assign ex2_allowin = ~(ld_stall | div_stall);

endmodule

// File: hdl/wb_exception_latch.sv
`timescale 1ns/1ns
module wb_exception_latch (
    input  logic           clk,
    input  logic           aresetn,
    input  logic           exception_in,
    input  logic           cpu_interrupt,
    input  wb_pkg::ecode_t ecode_in,
    input  wb_pkg::word_t  badv_in,
    input  wb_pkg::word_t  era_in,
    input  wb_pkg::word_t  csr_era,
    input  wb_pkg::word_t  eentry,
    input  wb_pkg::word_t  tlbrentry,
    input  wb_pkg::word_t  pc0,
    input  wb_pkg::uop_t   uop0,
    output logic           exception_out,
    output logic           wen_badv,
    output logic           wen_vppn,
    output logic           wen_era,
    output logic           tlb_exception,
    output logic           redirect_valid,
    output wb_pkg::ecode_t ecode_out,
    output wb_pkg::word_t  badv_out,
    output wb_pkg::word_t  era_out,
    output wb_pkg::word_t  redirect_pc,
    output logic [18:0]    vppn_out
);
    import wb_pkg::*;

    logic set_badv;
    logic set_vppn;

    // address faults write badv, page faults also write vppn
    always_comb begin
        set_badv = 1'b0;
        set_vppn = 1'b0;
        case (ecode_in)
            EXP_PIL, EXP_PIS, EXP_PIF, EXP_PME, EXP_PPI, EXP_TLBR: begin
                set_badv = 1'b1;
                set_vppn = 1'b1;
            end
            EXP_ADEF, EXP_ALE: begin
                set_badv = 1'b1;
            end
            default: begin
                set_badv = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exception_out <= 1'b0;
            wen_badv      <= 1'b0;
            wen_vppn      <= 1'b0;
            wen_era       <= 1'b0;
            tlb_exception <= 1'b0;
            era_out       <= '0;
        end else begin
            exception_out <= exception_in | cpu_interrupt;
            wen_badv      <= exception_in & set_badv;
            wen_vppn      <= exception_in & set_vppn;
            wen_era       <= exception_in | cpu_interrupt;
            tlb_exception <= exception_in && (ecode_in == EXP_TLBR);
            if (era_in != '0) begin
                era_out <= era_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        ecode_out <= (cpu_interrupt && !exception_in) ? EXP_INT : ecode_in;
        badv_out  <= badv_in;
        vppn_out  <= badv_in[18:0];
    end

    // tlb refill first, then general entry, then ertn
    always_comb begin
        if (tlb_exception) begin
            redirect_pc = tlbrentry;
        end else if (exception_out) begin
            redirect_pc = eentry;
        end else if (uop0[UOP_ERTN]) begin
            redirect_pc = csr_era;
        end else begin
            redirect_pc = pc0;
        end
    end

    assign redirect_valid = tlb_exception | exception_out | uop0[UOP_ERTN];

endmodule

// File: hdl/wb_result_select.sv
`timescale 1ns/1ns
module wb_result_select (
    input  logic             clk,
    input  logic             aresetn,
    input  wb_pkg::uop_t     uop0,
    input  wb_pkg::uop_t     uop1,
    input  wb_pkg::reg_idx_t rd0,
    input  wb_pkg::reg_idx_t rd1,
    input  wb_pkg::word_t    pc0,
    input  wb_pkg::word_t    result0,
    input  wb_pkg::word_t    result1,
    input  wb_pkg::word_t    csr_data,
    input  wb_pkg::word_t    quotient,
    input  wb_pkg::word_t    remainder,
    input  wb_pkg::word_t    ld_data,
    input  logic             result_valid0,
    input  logic             result_valid1,
    input  logic             csr_rd_en0,
    input  logic             div_ready,
    input  logic             dcache_ready,
    input  wb_pkg::reg_idx_t ld_rd,
    output logic             wb_we0,
    output logic             wb_we1,
    output logic             wb_we2,
    output wb_pkg::reg_idx_t wb_rd0,
    output wb_pkg::reg_idx_t wb_rd1,
    output wb_pkg::reg_idx_t wb_rd2,
    output wb_pkg::word_t    wb_data0,
    output wb_pkg::word_t    wb_data1,
    output wb_pkg::word_t    wb_data2
);
    import wb_pkg::*;

    logic  lane0_we;
    logic  lane1_we;
    word_t lane0_data;
    word_t lane1_data;
    word_t div_data0;
    word_t div_data1;

    assign div_data0 = uop0[UOP_REM] ? remainder : quotient;
    assign div_data1 = uop1[UOP_REM] ? remainder : quotient;

    // lane 0 takes alu, then csr, then divider
    always_comb begin
        lane0_we = 1'b1;
        if (result_valid0) begin
            lane0_data = uop0[UOP_LINK] ? pc0 + 32'd4 : result0;
        end else if (csr_rd_en0) begin
            lane0_data = csr_data;
        end else if (uop0[UOP_DIV] && div_ready) begin
            lane0_data = div_data0;
        end else begin
            lane0_we   = 1'b0;
            lane0_data = '0;
        end
    end

    // lane 1 has no csr path
    always_comb begin
        lane1_we = 1'b1;
        if (result_valid1) begin
            lane1_data = result1;
        end else if (uop1[UOP_DIV] && div_ready) begin
            lane1_data = div_data1;
        end else begin
            lane1_we   = 1'b0;
            lane1_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wb_we0 <= 1'b0;
            wb_we1 <= 1'b0;
            wb_we2 <= 1'b0;
        end else begin
            wb_we0 <= lane0_we;
            wb_we1 <= lane1_we;
            wb_we2 <= dcache_ready;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd0   <= rd0;
        wb_data0 <= lane0_data;
        wb_rd1   <= rd1;
        wb_data1 <= lane1_data;
        // load port only moves on a dcache return
        if (dcache_ready) begin
            wb_rd2   <= ld_rd;
            wb_data2 <= ld_data;
        end
    end

endmodule

// File: hdl/wb_pkg.sv
package wb_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  ecode_t;
    typedef logic [7:0]  uop_t;

    // flag positions in uop_t
    localparam int UOP_DIV  = 0;
    localparam int UOP_MEM  = 1;
    localparam int UOP_ERTN = 2;
    localparam int UOP_LINK = 3;
    localparam int UOP_REM  = 4;

    // exception codes
    localparam ecode_t EXP_INT  = 7'h00;
    localparam ecode_t EXP_PIL  = 7'h01;
    localparam ecode_t EXP_PIS  = 7'h02;
    localparam ecode_t EXP_PIF  = 7'h03;
    localparam ecode_t EXP_PME  = 7'h04;
    localparam ecode_t EXP_PPI  = 7'h07;
    localparam ecode_t EXP_ADEF = 7'h08;
    localparam ecode_t EXP_ALE  = 7'h09;
    localparam ecode_t EXP_SYS  = 7'h0b;
    localparam ecode_t EXP_TLBR = 7'h3f;

    // one quotient bit per step
    localparam int DIV_STEPS = 32;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

endpackage
